/* logic/hazard_pkg.sv */
package hazard_pkg;

	typedef enum logic [3:0] {
		NOP,
		CAL_R,
		CAL_I,
		LOAD_M,
		STORE_M,
		BRANCH,
		JUMP_I,
		JUMP_R,
		CMOV
	} dp_type_t;

	typedef struct packed {
		dp_type_t dptype; // Class, used for forwarding
		logic [4:0] id; // Instruction within class
	} kind_t;

	typedef logic [4:0] reg_t;

	typedef enum logic [2:0] {
		orig,
		e_rf,
		e_npc,
		e_md,
		m_npc,
		m_alu,
		m_md,
		w_rf
	} fwd_sel_t;

	typedef struct packed {
		logic [5:0] opcode;
		reg_t rs;
		reg_t rt;
		reg_t rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0] opcode;
		reg_t rs;
		reg_t rt;
		logic [15:0] imm; // Low 26 bits together form the J target
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_word_t;

	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;

	localparam logic [5:0] fn_jr = 6'h08;
	localparam logic [5:0] fn_movz = 6'h0a;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;

	localparam reg_t ra_reg = 5'd31; // Link register for jal

	// Register 0 is hardwired, so a write to it never forwards
	function automatic logic fwable(input reg_t src, input reg_t dst);
		return (src != 5'd0) && (src == dst);
	endfunction

endpackage

/* logic/stage_info_if.sv */
`timescale 1ns/1ps

interface stage_info_if;

	hazard_pkg::kind_t kind;
	hazard_pkg::reg_t reg1; // First source, rs
	hazard_pkg::reg_t reg2; // Second source, rt
	hazard_pkg::reg_t regw; // Destination

	modport producer (
		output kind,
		output reg1,
		output reg2,
		output regw
	);

	modport consumer (
		input kind,
		input reg1,
		input reg2,
		input regw
	);

endinterface

/* logic/instr_classify.sv */
`timescale 1ns/1ps

module instr_classify (
	input hazard_pkg::instr_word_t instr,
	stage_info_if.producer d
);

	always_comb begin
		d.kind = '{dptype: hazard_pkg::NOP, id: 5'd0};
		d.reg1 = '0;
		d.reg2 = '0;
		d.regw = '0;
		case (instr.i.opcode)
			hazard_pkg::op_special: begin
				case (instr.r.funct)
					hazard_pkg::fn_addu, hazard_pkg::fn_subu: begin
						d.kind.dptype = hazard_pkg::CAL_R;
						d.kind.id = {4'd0, instr.r.funct == hazard_pkg::fn_subu};
						d.reg1 = instr.r.rs;
						d.reg2 = instr.r.rt;
						d.regw = instr.r.rd;
					end
					hazard_pkg::fn_movz: begin
						d.kind.dptype = hazard_pkg::CMOV;
						d.reg1 = instr.r.rs;
						d.reg2 = instr.r.rt;
						d.regw = instr.r.rd; // Written only if rt is zero
					end
					hazard_pkg::fn_jr: begin
						d.kind.dptype = hazard_pkg::JUMP_R;
						d.reg1 = instr.r.rs;
					end
					default: ; // Unknown funct stays NOP
				endcase
			end
			hazard_pkg::op_ori, hazard_pkg::op_lui: begin
				d.kind.dptype = hazard_pkg::CAL_I;
				d.kind.id = {4'd0, instr.i.opcode == hazard_pkg::op_lui};
				d.reg1 = (instr.i.opcode == hazard_pkg::op_ori) ? instr.i.rs : 5'd0;
				d.regw = instr.i.rt;
			end
			hazard_pkg::op_lw: begin
				d.kind.dptype = hazard_pkg::LOAD_M;
				d.reg1 = instr.i.rs;
				d.regw = instr.i.rt;
			end
			hazard_pkg::op_sw: begin
				d.kind.dptype = hazard_pkg::STORE_M;
				d.reg1 = instr.i.rs; // Address base
				d.reg2 = instr.i.rt; // Store data
			end
			hazard_pkg::op_beq: begin
				d.kind.dptype = hazard_pkg::BRANCH;
				d.reg1 = instr.i.rs;
				d.reg2 = instr.i.rt;
			end
			hazard_pkg::op_j, hazard_pkg::op_jal: begin
				d.kind.dptype = hazard_pkg::JUMP_I;
				d.kind.id = {4'd0, instr.i.opcode == hazard_pkg::op_jal};
				d.regw = (instr.i.opcode == hazard_pkg::op_jal) ? hazard_pkg::ra_reg : 5'd0;
			end
			default: ;
		endcase
	end

endmodule

/* logic/hazard_pipe.sv */
`timescale 1ns/1ps

module hazard_pipe (
	input logic clk,
	input logic rst,
	input logic stall,
	stage_info_if.consumer d,
	stage_info_if.producer e,
	stage_info_if.producer m,
	stage_info_if.producer w
);

	localparam hazard_pkg::kind_t nop_kind = '{dptype: hazard_pkg::NOP, id: 5'd0};

	// Execute stage, bubble when decode is held
	always_ff @(posedge clk) begin
		if (rst || stall) begin
			e.kind <= nop_kind;
			e.reg1 <= '0;
			e.reg2 <= '0;
			e.regw <= '0;
		end else begin
			e.kind <= d.kind;
			e.reg1 <= d.reg1;
			e.reg2 <= d.reg2;
			e.regw <= d.regw;
		end
	end

	// Memory stage
	always_ff @(posedge clk) begin
		if (rst) begin
			m.kind <= nop_kind;
			m.reg1 <= '0;
			m.reg2 <= '0;
			m.regw <= '0;
		end else begin
			m.kind <= e.kind;
			m.reg1 <= e.reg1;
			m.reg2 <= e.reg2;
			m.regw <= e.regw;
		end
	end

	// Writeback stage
	always_ff @(posedge clk) begin
		if (rst) begin
			w.kind <= nop_kind;
			w.reg1 <= '0;
			w.reg2 <= '0;
			w.regw <= '0;
		end else begin
			w.kind <= m.kind;
			w.reg1 <= m.reg1;
			w.reg2 <= m.reg2;
			w.regw <= m.regw;
		end
	end

endmodule

/* logic/stall_detect.sv */
`timescale 1ns/1ps

module stall_detect (
	stage_info_if.consumer d,
	stage_info_if.consumer e,
	output logic stall
);

	logic d_reads_early;
	logic e_alu_result;
	logic reg_match;

	// Branch and jr compare in decode, so their operands are needed early
	assign d_reads_early = (d.kind.dptype == hazard_pkg::BRANCH) ||
		(d.kind.dptype == hazard_pkg::JUMP_R);

	// ALU result only exists at the end of execute
	assign e_alu_result = (e.kind.dptype == hazard_pkg::CAL_R) ||
		(e.kind.dptype == hazard_pkg::CAL_I);

	assign reg_match = hazard_pkg::fwable(d.reg1, e.regw) ||
		hazard_pkg::fwable(d.reg2, e.regw);

	assign stall = d_reads_early && e_alu_result && reg_match;

endmodule

/* logic/forward.sv */
`timescale 1ns/1ps

module forward (
	stage_info_if.consumer d,
	stage_info_if.consumer e,
	stage_info_if.consumer m,
	stage_info_if.consumer w,
	output hazard_pkg::fwd_sel_t fwd_d1,
	output hazard_pkg::fwd_sel_t fwd_d2,
	output hazard_pkg::fwd_sel_t fwd_e1,
	output hazard_pkg::fwd_sel_t fwd_e2,
	output hazard_pkg::fwd_sel_t fwd_m
);

	// Source from memory or writeback, memory first
	function automatic hazard_pkg::fwd_sel_t pick_mw(
		input hazard_pkg::reg_t r,
		input hazard_pkg::dp_type_t mt,
		input hazard_pkg::reg_t mw,
		input hazard_pkg::reg_t ww
	);
		logic m_hit;
		m_hit = hazard_pkg::fwable(r, mw);
		if (m_hit && (mt == hazard_pkg::JUMP_I || mt == hazard_pkg::JUMP_R))
			return hazard_pkg::m_npc;
		else if (m_hit && (mt == hazard_pkg::CAL_R || mt == hazard_pkg::CAL_I ||
				mt == hazard_pkg::CMOV))
			return hazard_pkg::m_alu;
		else if (m_hit && mt == hazard_pkg::LOAD_M)
			return hazard_pkg::m_md;
		else if (hazard_pkg::fwable(r, ww))
			return hazard_pkg::w_rf;
		return hazard_pkg::orig;
	endfunction

	// Decode operand, tries execute before the later stages
	function automatic hazard_pkg::fwd_sel_t pick_d(
		input hazard_pkg::reg_t r,
		input hazard_pkg::dp_type_t et,
		input hazard_pkg::reg_t ew,
		input hazard_pkg::dp_type_t mt,
		input hazard_pkg::reg_t mw,
		input hazard_pkg::reg_t ww
	);
		logic e_hit;
		e_hit = hazard_pkg::fwable(r, ew);
		if (e_hit && et == hazard_pkg::CMOV)
			return hazard_pkg::e_rf;
		else if (e_hit && (et == hazard_pkg::JUMP_I || et == hazard_pkg::JUMP_R))
			return hazard_pkg::e_npc;
		else if (e_hit && et == hazard_pkg::LOAD_M)
			return hazard_pkg::e_md;
		return pick_mw(r, mt, mw, ww); // CAL in execute falls through
	endfunction

	assign fwd_d1 = pick_d(d.reg1, e.kind.dptype, e.regw, m.kind.dptype, m.regw, w.regw);
	assign fwd_d2 = pick_d(d.reg2, e.kind.dptype, e.regw, m.kind.dptype, m.regw, w.regw);

	assign fwd_e1 = pick_mw(e.reg1, m.kind.dptype, m.regw, w.regw);
	assign fwd_e2 = pick_mw(e.reg2, m.kind.dptype, m.regw, w.regw);

	// Store data only
	assign fwd_m = hazard_pkg::fwable(m.reg2, w.regw) ? hazard_pkg::w_rf : hazard_pkg::orig;

endmodule

/* logic/hazard_ctrl.sv */
`timescale 1ns/1ps

module hazard_ctrl (
	input logic clk,
	input logic rst,
	input hazard_pkg::instr_word_t instr,
	output logic stall,
	output hazard_pkg::fwd_sel_t fwd_d1,
	output hazard_pkg::fwd_sel_t fwd_d2,
	output hazard_pkg::fwd_sel_t fwd_e1,
	output hazard_pkg::fwd_sel_t fwd_e2,
	output hazard_pkg::fwd_sel_t fwd_m
);

	stage_info_if d_info ();
	stage_info_if e_info ();
	stage_info_if m_info ();
	stage_info_if w_info ();

	instr_classify instr_classify_i (
		.instr(instr),
		.d(d_info.producer)
	);

	hazard_pipe hazard_pipe_i (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.d(d_info.consumer),
		.e(e_info.producer),
		.m(m_info.producer),
		.w(w_info.producer)
	);

	stall_detect stall_detect_i (
		.d(d_info.consumer),
		.e(e_info.consumer),
		.stall(stall)
	);

	forward forward_i (
		.d(d_info.consumer),
		.e(e_info.consumer),
		.m(m_info.consumer),
		.w(w_info.consumer),
		.fwd_d1(fwd_d1),
		.fwd_d2(fwd_d2),
		.fwd_e1(fwd_e1),
		.fwd_e2(fwd_e2),
		.fwd_m(fwd_m)
	);

endmodule

/* test/hazard_ctrl_tb.sv */
`timescale 1ns/1ps

module hazard_ctrl_tb;

	localparam int n_issue = 2000; // Directed words first, then random
	localparam int reset_cycles = 10;
	localparam int cycle_limit = 3 * (n_issue + reset_cycles);

	logic clk;
	logic rst;
	hazard_pkg::instr_word_t instr;
	logic stall;
	hazard_pkg::fwd_sel_t fwd_d1;
	hazard_pkg::fwd_sel_t fwd_d2;
	hazard_pkg::fwd_sel_t fwd_e1;
	hazard_pkg::fwd_sel_t fwd_e2;
	hazard_pkg::fwd_sel_t fwd_m;

	// Model copies of the later stages
	hazard_pkg::dp_type_t e_t;
	hazard_pkg::dp_type_t m_t;
	hazard_pkg::reg_t e_r1;
	hazard_pkg::reg_t e_r2;
	hazard_pkg::reg_t e_rw;
	hazard_pkg::reg_t m_r2;
	hazard_pkg::reg_t m_rw;
	hazard_pkg::reg_t w_rw;

	hazard_pkg::instr_word_t directed[$];
	int cycles = 0;

	hazard_ctrl hazard_ctrl_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.stall(stall),
		.fwd_d1(fwd_d1),
		.fwd_d2(fwd_d2),
		.fwd_e1(fwd_e1),
		.fwd_e2(fwd_e2),
		.fwd_m(fwd_m)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Something failed");
			$fatal(1, "Timeout");
		end
	end

	task automatic check_sel(input string name, input hazard_pkg::fwd_sel_t exp,
			input hazard_pkg::fwd_sel_t act);
		if (act !== exp) begin
			$display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
			$display("Something failed");
			$fatal(1, "Select mismatch on %s", name);
		end
	endtask

	task automatic check_stall(input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED at %0t: stall expected %b, got %b", $time, exp, act);
			$display("Something failed");
			$fatal(1, "Stall mismatch");
		end
	endtask

	function automatic hazard_pkg::instr_word_t r_format(input logic [5:0] fn,
			input hazard_pkg::reg_t rs, input hazard_pkg::reg_t rt, input hazard_pkg::reg_t rd);
		return {hazard_pkg::op_special, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic hazard_pkg::instr_word_t i_format(input logic [5:0] op,
			input hazard_pkg::reg_t rs, input hazard_pkg::reg_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic hazard_pkg::instr_word_t random_word();
		hazard_pkg::reg_t rs;
		hazard_pkg::reg_t rt;
		hazard_pkg::reg_t rd;
		logic [15:0] imm;
		rs = 5'($urandom % 8); // Few registers, many hazards
		rt = 5'($urandom % 8);
		rd = 5'($urandom % 8);
		imm = 16'($urandom);
		case ($urandom % 12)
			0: return r_format(hazard_pkg::fn_addu, rs, rt, rd);
			1: return r_format(hazard_pkg::fn_subu, rs, rt, rd);
			2: return i_format(hazard_pkg::op_ori, rs, rt, imm);
			3: return i_format(hazard_pkg::op_lui, 0, rt, imm);
			4: return i_format(hazard_pkg::op_lw, rs, rt, imm);
			5: return i_format(hazard_pkg::op_sw, rs, rt, imm);
			6: return i_format(hazard_pkg::op_beq, rs, rt, imm);
			7: return i_format(hazard_pkg::op_j, rs, rt, imm);
			8: return i_format(hazard_pkg::op_jal, rs, rt, imm);
			9: return r_format(hazard_pkg::fn_jr, rs, 0, 0);
			10: return r_format(hazard_pkg::fn_movz, rs, rt, rd);
			default: return '0;
		endcase
	endfunction

	task automatic decode_word(input hazard_pkg::instr_word_t w, output hazard_pkg::dp_type_t t,
			output hazard_pkg::reg_t r1, output hazard_pkg::reg_t r2, output hazard_pkg::reg_t rw);
		logic [5:0] op;
		logic [5:0] fn;
		op = w[31:26];
		fn = w[5:0];
		t = hazard_pkg::NOP;
		r1 = 0;
		r2 = 0;
		rw = 0;
		if (op == hazard_pkg::op_special) begin
			if (fn == hazard_pkg::fn_addu || fn == hazard_pkg::fn_subu ||
					fn == hazard_pkg::fn_movz) begin
				t = (fn == hazard_pkg::fn_movz) ? hazard_pkg::CMOV : hazard_pkg::CAL_R;
				r1 = w[25:21];
				r2 = w[20:16];
				rw = w[15:11];
			end else if (fn == hazard_pkg::fn_jr) begin
				t = hazard_pkg::JUMP_R;
				r1 = w[25:21];
			end
		end else if (op == hazard_pkg::op_ori || op == hazard_pkg::op_lui) begin
			t = hazard_pkg::CAL_I;
			r1 = (op == hazard_pkg::op_ori) ? w[25:21] : 5'd0; // lui has no source
			rw = w[20:16];
		end else if (op == hazard_pkg::op_lw) begin
			t = hazard_pkg::LOAD_M;
			r1 = w[25:21];
			rw = w[20:16];
		end else if (op == hazard_pkg::op_sw || op == hazard_pkg::op_beq) begin
			t = (op == hazard_pkg::op_sw) ? hazard_pkg::STORE_M : hazard_pkg::BRANCH;
			r1 = w[25:21];
			r2 = w[20:16];
		end else if (op == hazard_pkg::op_j || op == hazard_pkg::op_jal) begin
			t = hazard_pkg::JUMP_I;
			rw = (op == hazard_pkg::op_jal) ? 5'd31 : 5'd0;
		end
	endtask

	function automatic logic hits(input hazard_pkg::reg_t src, input hazard_pkg::reg_t dst);
		return (src != 0) && (src == dst);
	endfunction

	// Memory before writeback
	function automatic hazard_pkg::fwd_sel_t late_source(input hazard_pkg::reg_t r);
		if (hits(r, m_rw)) begin
			case (m_t)
				hazard_pkg::JUMP_I, hazard_pkg::JUMP_R: return hazard_pkg::m_npc;
				hazard_pkg::CAL_R, hazard_pkg::CAL_I, hazard_pkg::CMOV: return hazard_pkg::m_alu;
				hazard_pkg::LOAD_M: return hazard_pkg::m_md;
				default: ;
			endcase
		end
		if (hits(r, w_rw))
			return hazard_pkg::w_rf;
		return hazard_pkg::orig;
	endfunction

	function automatic hazard_pkg::fwd_sel_t decode_source(input hazard_pkg::reg_t r);
		if (hits(r, e_rw)) begin
			case (e_t)
				hazard_pkg::CMOV: return hazard_pkg::e_rf;
				hazard_pkg::JUMP_I, hazard_pkg::JUMP_R: return hazard_pkg::e_npc;
				hazard_pkg::LOAD_M: return hazard_pkg::e_md;
				default: ; // ALU result not ready yet
			endcase
		end
		return late_source(r);
	endfunction

	initial begin
		hazard_pkg::instr_word_t cur;
		hazard_pkg::dp_type_t d_t;
		hazard_pkg::reg_t d_r1;
		hazard_pkg::reg_t d_r2;
		hazard_pkg::reg_t d_rw;
		logic exp_stall;
		int issued;
		void'($urandom(95));
		rst = 1'b1;
		instr = '0;
		cur = '0;
		issued = 0;
		e_t = hazard_pkg::NOP;
		m_t = hazard_pkg::NOP;
		{e_r1, e_r2, e_rw, m_r2, m_rw, w_rw} = '0;
		directed.push_back(r_format(hazard_pkg::fn_addu, 2, 3, 1));
		directed.push_back(i_format(hazard_pkg::op_beq, 1, 4, 16'd0)); // Stall on $1
		directed.push_back(i_format(hazard_pkg::op_ori, 1, 5, 16'h7));
		directed.push_back(r_format(hazard_pkg::fn_jr, 5, 0, 0)); // Stall on $5
		directed.push_back(i_format(hazard_pkg::op_lw, 5, 6, 16'd0));
		directed.push_back(i_format(hazard_pkg::op_beq, 6, 0, 16'd0)); // e_md
		directed.push_back(i_format(hazard_pkg::op_jal, 0, 0, 16'h40));
		directed.push_back(r_format(hazard_pkg::fn_addu, 31, 31, 2)); // e_npc
		directed.push_back(r_format(hazard_pkg::fn_movz, 2, 0, 3));
		directed.push_back(i_format(hazard_pkg::op_sw, 0, 3, 16'd0)); // e_rf
		directed.push_back(i_format(hazard_pkg::op_ori, 0, 4, 16'd1));
		directed.push_back(i_format(hazard_pkg::op_sw, 0, 4, 16'd4)); // w_rf on memory
		directed.push_back(r_format(hazard_pkg::fn_addu, 1, 1, 7));
		directed.push_back(i_format(hazard_pkg::op_ori, 7, 7, 16'd1));
		directed.push_back(i_format(hazard_pkg::op_j, 0, 0, 16'd0));
		directed.push_back(r_format(hazard_pkg::fn_addu, 7, 7, 1)); // M beats W
		directed.push_back(r_format(hazard_pkg::fn_addu, 0, 0, 0));
		directed.push_back(i_format(hazard_pkg::op_beq, 0, 0, 16'd0)); // $0 stays orig
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
		// First pass sees the reset state
		while (issued < n_issue) begin
			@(negedge clk);
			decode_word(cur, d_t, d_r1, d_r2, d_rw);
			exp_stall = (d_t == hazard_pkg::BRANCH || d_t == hazard_pkg::JUMP_R) &&
				(e_t == hazard_pkg::CAL_R || e_t == hazard_pkg::CAL_I) &&
				(hits(d_r1, e_rw) || hits(d_r2, e_rw));
			check_stall(exp_stall, stall);
			check_sel("fwd_d1", decode_source(d_r1), fwd_d1);
			check_sel("fwd_d2", decode_source(d_r2), fwd_d2);
			check_sel("fwd_e1", late_source(e_r1), fwd_e1);
			check_sel("fwd_e2", late_source(e_r2), fwd_e2);
			check_sel("fwd_m", hits(m_r2, w_rw) ? hazard_pkg::w_rf : hazard_pkg::orig, fwd_m);
			@(posedge clk);
			w_rw = m_rw;
			m_t = e_t;
			m_r2 = e_r2;
			m_rw = e_rw;
			if (exp_stall) begin
				e_t = hazard_pkg::NOP; // Bubble
				{e_r1, e_r2, e_rw} = '0;
			end else begin
				e_t = d_t;
				{e_r1, e_r2, e_rw} = {d_r1, d_r2, d_rw};
				cur = (directed.size() > 0) ? directed.pop_front() : random_word();
				issued++;
			end
			instr <= cur;
		end
		$display("Everything OK");
		$finish;
	end

endmodule

/* list.f */
logic/hazard_pkg.sv
logic/stage_info_if.sv
logic/instr_classify.sv
logic/hazard_pipe.sv
logic/stall_detect.sv
logic/forward.sv
logic/hazard_ctrl.sv
test/hazard_ctrl_tb.sv

/* Bender.yml */
package:
  name: hazard_ctrl

sources:
  - logic/hazard_pkg.sv
  - logic/stage_info_if.sv
  - logic/instr_classify.sv
  - logic/hazard_pipe.sv
  - logic/stall_detect.sv
  - logic/forward.sv
  - logic/hazard_ctrl.sv
  - target: test
    files:
      - test/hazard_ctrl_tb.sv
